// ==== bbcKeyboard.f ====
common/ps2Pkg.sv
common/bbcKeyPkg.sv
ps2/ps2Receiver.sv
ps2/scancodeTranslator.sv
hw/columnScanner.sv
hw/keyMatrix.sv
hw/bbcKeyboard.sv
test/bbcKeyboardTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = bbcKeyboardTb
FILELIST  = bbcKeyboard.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/bbcKeyboardTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bbcKeyboardTb;
	import bbcKeyPkg::*;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int SCAN_DIVIDE = 8;
	localparam int HALF_BIT = 10; // CLK cycles per PS/2 clock phase
	localparam int KEY_WAIT = 100;
	localparam int TABLE_SIZE = 10;

	typedef struct packed {
		logic [7:0] code;
		bbcKey_t key;
	} tableEntry_t;

	// make code, row, column
	localparam tableEntry_t KEY_TABLE [TABLE_SIZE] = '{
		{8'h1E, 3'd4, 4'd1}, // a
		{8'h10, 3'd1, 4'd0}, // q
		{8'h39, 3'd6, 4'd2}, // space
		{8'h1C, 3'd4, 4'd9}, // return
		{8'h02, 3'd3, 4'd0}, // 1
		{8'h2C, 3'd6, 4'd1}, // z
		{8'h3B, 3'd7, 4'd1}, // f1
		{8'h26, 3'd5, 4'd6}, // l
		{8'h32, 3'd6, 4'd5}, // m
		{8'h0B, 3'd2, 4'd7}  // 0
	};

	logic CLK;
	logic nRESET;
	logic ps2Clk;
	logic ps2Data;
	logic autoscan;
	logic [3:0] column;
	logic [2:0] row;
	logic [3:0] scanColumn;
	logic columnMatch;
	logic rowMatch;

	logic [7:0] expectState [COLUMNS]; // expected matrix, one word per column
	int held[$]; // table indices of pressed keys
	int errorCount;
	int testCount;
	int failedTests;
	int errorsAtStart;

	bbcKeyboard #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES),
		.SCAN_DIVIDE(SCAN_DIVIDE)
	) uut (
		.CLK(CLK),
		.nRESET(nRESET),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.autoscan(autoscan),
		.column(column),
		.row(row),
		.scanColumn(scanColumn),
		.columnMatch(columnMatch),
		.rowMatch(rowMatch)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic waitCycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// bit 0 goes out first; a count below 11 cuts the frame short
	task automatic sendFrame(input logic [7:0] code, input logic badParity, input int count);
		logic [10:0] bits;
		int i;
		bits = {1'b1, (~^code) ^ badParity, code, 1'b0}; // stop, odd parity, data, start
		@(posedge CLK);
		for (i = 0; i < count; i++) begin
			ps2Data <= bits[i];
			waitCycles(HALF_BIT);
			ps2Clk <= 1'b0; // device changes data while the clock is high
			waitCycles(HALF_BIT);
			ps2Clk <= 1'b1;
		end
		ps2Data <= 1'b1;
		waitCycles(HALF_BIT);
	endtask

	task automatic sendCode(input logic [7:0] code);
		sendFrame(code, 1'b0, 11);
	endtask

	task automatic waitForKey(input logic [3:0] c, input logic [2:0] r, input logic expected);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		column <= c;
		row <= r;
		@(negedge CLK);
		while (rowMatch !== expected && cycles < KEY_WAIT) begin
			@(negedge CLK);
			cycles++;
		end
		if (rowMatch !== expected) begin
			$display("timed out waiting for the key at column %0d row %0d to go %s",
				c, r, expected ? "down" : "up");
			errorCount++;
		end
	endtask

	task automatic checkKey(input logic [3:0] c, input logic [2:0] r);
		logic expectRow;
		logic expectColumn;
		expectRow = expectState[c][r];
		expectColumn = |expectState[c];
		@(posedge CLK);
		column <= c;
		row <= r;
		@(negedge CLK); // outputs settled
		if (rowMatch !== expectRow) begin
			$display("** Error: rowMatch at column %h row %h is %h, expected %h",
				c, r, rowMatch, expectRow);
			errorCount++;
		end
		if (columnMatch !== expectColumn) begin
			$display("** Error: columnMatch at column %h is %h, expected %h",
				c, columnMatch, expectColumn);
			errorCount++;
		end
	endtask

	task automatic checkAllKeys();
		int c;
		int r;
		for (c = 0; c < COLUMNS; c++) begin
			for (r = 0; r < ROWS; r++) begin
				checkKey(c[3:0], r[2:0]);
			end
		end
	endtask

	task automatic reportTest(input string name);
		testCount++;
		if (errorCount == errorsAtStart) begin
			$display("%s: ok", name);
		end else begin
			failedTests++;
			$display("%s: %0d errors", name, errorCount - errorsAtStart);
		end
		errorsAtStart = errorCount;
	endtask

	task automatic resetState();
		checkAllKeys();
		if (scanColumn !== 4'h0) begin
			$display("** Error: scanColumn after reset is %h, expected %h", scanColumn, 4'h0);
			errorCount++;
		end
		reportTest("reset");
	endtask

	task automatic pressKeys();
		int n;
		int idx;
		bbcKey_t key;
		for (n = 0; n < 4; n++) begin
			idx = int'($urandom % TABLE_SIZE);
			key = KEY_TABLE[idx].key;
			sendCode(KEY_TABLE[idx].code);
			expectState[key.column][key.row] = 1'b1;
			held.push_back(idx);
			waitForKey(key.column, key.row, 1'b1);
			checkKey(key.column, key.row);
			checkKey(key.column, key.row ^ 3'd1); // neighbour row in the same column
		end
		reportTest("press");
	endtask

	task automatic releaseKeys();
		int idx;
		bbcKey_t key;
		while (held.size() > 0) begin
			idx = held.pop_front();
			key = KEY_TABLE[idx].key;
			sendCode(KEY_TABLE[idx].code | 8'h80);
			expectState[key.column][key.row] = 1'b0;
			waitForKey(key.column, key.row, 1'b0);
			checkAllKeys(); // the others still held
		end
		reportTest("release");
	endtask

	task automatic prefixAndUnknown();
		sendCode(8'hE0);
		sendCode(8'h48); // up arrow
		expectState[9][3] = 1'b1;
		waitForKey(4'd9, 3'd3, 1'b1);
		checkKey(4'd9, 3'd3);
		sendCode(8'h5A); // no table entry
		sendFrame(8'h1E, 1'b1, 11); // a with bad parity
		sendCode(8'hC8); // up released, lands only after the two frames above
		expectState[9][3] = 1'b0;
		waitForKey(4'd9, 3'd3, 1'b0);
		checkAllKeys();
		reportTest("prefix and unknown");
	endtask

	task automatic stallRecovery();
		sendFrame(8'h1E, 1'b0, 4);
		waitCycles(TIMEOUT_CYCLES + 50); // receiver should give up on the frame
		sendCode(8'h10); // q
		expectState[0][1] = 1'b1;
		waitForKey(4'd0, 3'd1, 1'b1);
		checkAllKeys();
		reportTest("stall recovery");
	endtask

	task automatic autoscanSweep();
		logic [3:0] last;
		logic [3:0] nextColumn;
		int step;
		int cycles;
		@(posedge CLK);
		autoscan <= 1'b1;
		@(negedge CLK);
		last = scanColumn;
		for (step = 0; step < COLUMNS; step++) begin
			cycles = 0;
			while (scanColumn === last && cycles < 4 * SCAN_DIVIDE) begin
				@(negedge CLK);
				cycles++;
			end
			nextColumn = last + 4'd1; // wraps from 15 to 0
			if (scanColumn === last) begin
				$display("scanColumn did not step away from %0d in time", last);
				errorCount++;
			end else if (scanColumn !== nextColumn) begin
				$display("** Error: scanColumn is %h, expected %h", scanColumn, nextColumn);
				errorCount++;
			end
			if (columnMatch !== (|expectState[scanColumn])) begin
				$display("** Error: columnMatch at scanColumn %h is %h, expected %h",
					scanColumn, columnMatch, |expectState[scanColumn]);
				errorCount++;
			end
			last = scanColumn;
		end
		@(posedge CLK);
		autoscan <= 1'b0;
		@(negedge CLK);
		last = scanColumn;
		waitCycles(3 * SCAN_DIVIDE);
		@(negedge CLK);
		if (scanColumn !== last) begin
			$display("** Error: scanColumn is %h with autoscan low, expected %h", scanColumn, last);
			errorCount++;
		end
		reportTest("autoscan");
	endtask

	initial begin
		void'($urandom(3238));
		nRESET = 1'b0;
		ps2Clk = 1'b1; // PS/2 lines idle high
		ps2Data = 1'b1;
		autoscan = 1'b0;
		column = 4'd0;
		row = 3'd0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		errorsAtStart = 0;
		foreach (expectState[i]) expectState[i] = 8'h00;
		waitCycles(3);
		nRESET <= 1'b1;
		resetState();
		pressKeys();
		releaseKeys();
		prefixAndUnknown();
		stallRecovery();
		autoscanSweep();
		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/bbcKeyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module bbcKeyboard #(
	parameter int TIMEOUT_CYCLES = 2000,
	parameter int SCAN_DIVIDE = 32
) (
	input wire logic CLK,
	input wire logic nRESET,
	input wire logic ps2Clk,
	input wire logic ps2Data,
	input wire logic autoscan,
	input wire bbcKeyPkg::keyColumn_t column,
	input wire bbcKeyPkg::keyRow_t row,
	output bbcKeyPkg::keyColumn_t scanColumn,
	output logic columnMatch,
	output logic rowMatch
);
	import ps2Pkg::*;
	import bbcKeyPkg::*;

	scanCode_t scanCode;
	logic scanCodeValid;
	keyEvent_t keyEvent;
	logic keyEventValid;

	ps2Receiver #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) receiver (
		.CLK(CLK),
		.nRESET(nRESET),
		.ps2Clk(ps2Clk),
		.ps2Data(ps2Data),
		.scanCode(scanCode),
		.scanCodeValid(scanCodeValid)
	);

	scancodeTranslator translator (
		.CLK(CLK),
		.nRESET(nRESET),
		.scanCode(scanCode),
		.scanCodeValid(scanCodeValid),
		.keyEvent(keyEvent),
		.keyEventValid(keyEventValid)
	);

	columnScanner #(
		.SCAN_DIVIDE(SCAN_DIVIDE)
	) scanner (
		.CLK(CLK),
		.nRESET(nRESET),
		.autoscan(autoscan),
		.scanColumn(scanColumn)
	);

	keyMatrix matrix (
		.CLK(CLK),
		.nRESET(nRESET),
		.keyEvent(keyEvent),
		.keyEventValid(keyEventValid),
		.autoscan(autoscan),
		.scanColumn(scanColumn),
		.column(column),
		.row(row),
		.columnMatch(columnMatch),
		.rowMatch(rowMatch)
	);

endmodule

`default_nettype wire

// ==== hw/keyMatrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module keyMatrix (
	input wire logic CLK,
	input wire logic nRESET,
	input wire bbcKeyPkg::keyEvent_t keyEvent,
	input wire logic keyEventValid,
	input wire logic autoscan,
	input wire bbcKeyPkg::keyColumn_t scanColumn,
	input wire bbcKeyPkg::keyColumn_t column,
	input wire bbcKeyPkg::keyRow_t row,
	output logic columnMatch,
	output logic rowMatch
);
	import bbcKeyPkg::*;

	logic [COLUMNS-1:0][ROWS-1:0] keyState; // one word per column
	keyColumn_t selColumn;
	logic [ROWS-1:0] columnWord;

	// release codes clear keys directly, no periodic wipe needed
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			keyState <= '0;
		end else if (keyEventValid) begin
			keyState[keyEvent.key.column][keyEvent.key.row] <= keyEvent.pressed;
		end
	end

	assign selColumn = autoscan ? scanColumn : column;
	assign columnWord = keyState[selColumn];

	assign columnMatch = |columnWord; // any key down in this column
	assign rowMatch = columnWord[row];

	assert property (@(posedge CLK) disable iff (!nRESET)
		rowMatch |-> columnMatch)
		else $error("rowMatch without columnMatch");

endmodule

`default_nettype wire

// ==== hw/columnScanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module columnScanner #(
	parameter int SCAN_DIVIDE = 32
) (
	input wire logic CLK,
	input wire logic nRESET,
	input wire logic autoscan,
	output bbcKeyPkg::keyColumn_t scanColumn
);
	import bbcKeyPkg::*;

	localparam int DIV_WIDTH = (SCAN_DIVIDE > 1) ? $clog2(SCAN_DIVIDE) : 1;
	localparam logic [DIV_WIDTH-1:0] DIV_LAST = DIV_WIDTH'(SCAN_DIVIDE - 1);
	localparam keyColumn_t LAST_COLUMN = keyColumn_t'(COLUMNS - 1);

	logic [DIV_WIDTH-1:0] divCount;

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			divCount <= '0;
			scanColumn <= '0;
		end else if (!autoscan) begin
			divCount <= '0; // full period after autoscan returns
		end else if (divCount == DIV_LAST) begin
			divCount <= '0;
			scanColumn <= (scanColumn == LAST_COLUMN) ? '0 : scanColumn + 1'b1;
		end else begin
			divCount <= divCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== ps2/scancodeTranslator.sv ====
`timescale 1ns/1ps
`default_nettype none

module scancodeTranslator (
	input wire logic CLK,
	input wire logic nRESET,
	input wire ps2Pkg::scanCode_t scanCode,
	input wire logic scanCodeValid,
	output bbcKeyPkg::keyEvent_t keyEvent,
	output logic keyEventValid
);
	import ps2Pkg::*;
	import bbcKeyPkg::*;

	scanCode_t makeCode;
	logic isPrefix;
	logic extended;
	logic fakeShift;
	logic tableHit;
	bbcKey_t tableKey;

	always_comb begin
		makeCode = scanCode;
		makeCode[RELEASE_BIT] = 1'b0;
	end

	assign isPrefix = (scanCode == PREFIX_EXTENDED);

	// extended keys wrap themselves in E0 2A / E0 36 shift codes; those are not real shifts
	assign fakeShift = extended && (makeCode == 8'h2A || makeCode == 8'h36);

	always_comb begin
		tableHit = 1'b1;
		case (makeCode)
			8'h01: tableKey = bbcKey_t'(7'h70); // escape
			8'h02: tableKey = bbcKey_t'(7'h30); // 1
			8'h03: tableKey = bbcKey_t'(7'h31);
			8'h04: tableKey = bbcKey_t'(7'h11);
			8'h05: tableKey = bbcKey_t'(7'h12);
			8'h06: tableKey = bbcKey_t'(7'h13);
			8'h07: tableKey = bbcKey_t'(7'h34);
			8'h08: tableKey = bbcKey_t'(7'h24);
			8'h09: tableKey = bbcKey_t'(7'h15);
			8'h0A: tableKey = bbcKey_t'(7'h26);
			8'h0B: tableKey = bbcKey_t'(7'h27); // 0
			8'h0C: tableKey = bbcKey_t'(7'h17); // minus
			8'h0E: tableKey = bbcKey_t'(7'h59); // backspace as delete
			8'h0F: tableKey = bbcKey_t'(7'h60); // tab
			8'h10: tableKey = bbcKey_t'(7'h10); // q
			8'h11: tableKey = bbcKey_t'(7'h21);
			8'h12: tableKey = bbcKey_t'(7'h22);
			8'h13: tableKey = bbcKey_t'(7'h33);
			8'h14: tableKey = bbcKey_t'(7'h23);
			8'h15: tableKey = bbcKey_t'(7'h44);
			8'h16: tableKey = bbcKey_t'(7'h35);
			8'h17: tableKey = bbcKey_t'(7'h25);
			8'h18: tableKey = bbcKey_t'(7'h36);
			8'h19: tableKey = bbcKey_t'(7'h37); // p
			8'h1A: tableKey = bbcKey_t'(7'h38); // left bracket
			8'h1B: tableKey = bbcKey_t'(7'h58); // right bracket
			8'h1C: tableKey = bbcKey_t'(7'h49); // return
			8'h1D: tableKey = bbcKey_t'(7'h01); // ctrl
			8'h1E: tableKey = bbcKey_t'(7'h41); // a
			8'h1F: tableKey = bbcKey_t'(7'h51);
			8'h20: tableKey = bbcKey_t'(7'h32);
			8'h21: tableKey = bbcKey_t'(7'h43);
			8'h22: tableKey = bbcKey_t'(7'h53);
			8'h23: tableKey = bbcKey_t'(7'h54);
			8'h24: tableKey = bbcKey_t'(7'h45);
			8'h25: tableKey = bbcKey_t'(7'h46);
			8'h26: tableKey = bbcKey_t'(7'h56); // l
			8'h27: tableKey = bbcKey_t'(7'h57); // semicolon
			8'h28: tableKey = bbcKey_t'(7'h28); // quote as underscore
			8'h29: tableKey = bbcKey_t'(7'h18); // backtick as caret
			8'h2A: tableKey = bbcKey_t'(7'h00); // left shift
			8'h2B: tableKey = bbcKey_t'(7'h78); // backslash
			8'h2C: tableKey = bbcKey_t'(7'h61); // z
			8'h2D: tableKey = bbcKey_t'(7'h42);
			8'h2E: tableKey = bbcKey_t'(7'h52);
			8'h2F: tableKey = bbcKey_t'(7'h63);
			8'h30: tableKey = bbcKey_t'(7'h64);
			8'h31: tableKey = bbcKey_t'(7'h55);
			8'h32: tableKey = bbcKey_t'(7'h65); // m
			8'h33: tableKey = bbcKey_t'(7'h66); // comma
			8'h34: tableKey = bbcKey_t'(7'h67); // full stop
			8'h35: tableKey = bbcKey_t'(7'h68); // slash
			8'h36: tableKey = bbcKey_t'(7'h00); // right shift
			8'h38: tableKey = bbcKey_t'(7'h50); // alt as shift lock
			8'h39: tableKey = bbcKey_t'(7'h62); // space
			8'h3A: tableKey = bbcKey_t'(7'h40); // caps lock
			8'h3B: tableKey = bbcKey_t'(7'h71); // f1
			8'h3C: tableKey = bbcKey_t'(7'h72);
			8'h3D: tableKey = bbcKey_t'(7'h73);
			8'h3E: tableKey = bbcKey_t'(7'h14);
			8'h3F: tableKey = bbcKey_t'(7'h74);
			8'h40: tableKey = bbcKey_t'(7'h75);
			8'h41: tableKey = bbcKey_t'(7'h16);
			8'h42: tableKey = bbcKey_t'(7'h76);
			8'h43: tableKey = bbcKey_t'(7'h77); // f9
			8'h44: tableKey = bbcKey_t'(7'h20); // f10 as f0
			8'h47: tableKey = bbcKey_t'(7'h47); // home as at sign
			8'h48: tableKey = bbcKey_t'(7'h39); // up
			8'h4B: tableKey = bbcKey_t'(7'h19); // left
			8'h4D: tableKey = bbcKey_t'(7'h79); // right
			8'h4F: tableKey = bbcKey_t'(7'h48); // end as colon
			8'h50: tableKey = bbcKey_t'(7'h29); // down
			8'h51: tableKey = bbcKey_t'(7'h69); // page down as copy
			default: begin
				tableHit = 1'b0; // not on the matrix
				tableKey = '0;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			extended <= 1'b0;
			keyEventValid <= 1'b0;
		end else begin
			keyEventValid <= scanCodeValid && !isPrefix && tableHit && !fakeShift;
			if (scanCodeValid) begin
				extended <= isPrefix; // lasts for one code only
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (scanCodeValid) begin
			keyEvent.key <= tableKey;
			keyEvent.pressed <= ~scanCode[RELEASE_BIT];
		end
	end

	assert property (@(posedge CLK) disable iff (!nRESET)
		keyEventValid |-> $past(scanCodeValid))
		else $error("keyEventValid without a scan code one cycle earlier");

endmodule

`default_nettype wire

// ==== ps2/ps2Receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2Receiver #(
	parameter int TIMEOUT_CYCLES = 2000
) (
	input wire logic CLK,
	input wire logic nRESET,
	input wire logic ps2Clk,
	input wire logic ps2Data,
	output ps2Pkg::scanCode_t scanCode,
	output logic scanCodeValid
);
	import ps2Pkg::*;

	localparam int COUNT_WIDTH = $clog2(FRAME_BITS + 1);
	localparam int IDLE_WIDTH = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(FRAME_BITS - 1);
	localparam logic [IDLE_WIDTH-1:0] IDLE_LIMIT = IDLE_WIDTH'(TIMEOUT_CYCLES - 1);

	logic [1:0] clkSync;
	logic [1:0] dataSync;
	logic clkPrev;
	logic fallingEdge;
	logic [COUNT_WIDTH-1:0] bitCount;
	logic [IDLE_WIDTH-1:0] idleCount;
	logic [FRAME_BITS-2:0] shiftReg;
	ps2Frame_t frame;
	logic frameGood;

	// both lines idle high
	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			clkSync <= 2'b11;
			dataSync <= 2'b11;
			clkPrev <= 1'b1;
		end else begin
			clkSync <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkPrev <= clkSync[1];
		end
	end

	assign fallingEdge = clkPrev & ~clkSync[1];

	// stop bit is the live sample, the rest sits in the shifter
	assign frame = {dataSync[1], shiftReg};
	assign frameGood = !frame.start && frame.stop && (^{frame.parity, frame.data});

	always_ff @(posedge CLK) begin
		if (!nRESET) begin
			bitCount <= '0;
			idleCount <= '0;
			scanCodeValid <= 1'b0;
		end else begin
			scanCodeValid <= 1'b0;
			if (fallingEdge) begin
				idleCount <= '0;
				if (bitCount == LAST_BIT) begin
					bitCount <= '0;
					scanCodeValid <= frameGood; // bad frames vanish here
				end else begin
					bitCount <= bitCount + 1'b1;
				end
			end else if (bitCount != '0) begin
				if (idleCount == IDLE_LIMIT) begin // keyboard stalled mid-frame
					bitCount <= '0;
					idleCount <= '0;
				end else begin
					idleCount <= idleCount + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (fallingEdge) begin
			shiftReg <= {dataSync[1], shiftReg[FRAME_BITS-2:1]}; // LSB first
		end
		if (fallingEdge && bitCount == LAST_BIT) begin
			scanCode <= frame.data; // held until the next frame completes
		end
	end

	assert property (@(posedge CLK) disable iff (!nRESET)
		scanCodeValid |=> !scanCodeValid)
		else $error("scanCodeValid high for two cycles");

	assert property (@(posedge CLK) disable iff (!nRESET)
		bitCount <= FRAME_BITS)
		else $error("bitCount beyond frame length");

endmodule

`default_nettype wire

// ==== common/bbcKeyPkg.sv ====
`default_nettype none

package bbcKeyPkg;

	localparam int ROWS = 8;
	localparam int COLUMNS = 16;

	typedef logic [$clog2(ROWS)-1:0] keyRow_t;
	typedef logic [$clog2(COLUMNS)-1:0] keyColumn_t;

	// row in the upper bits, same layout as the 7-bit matrix code
	typedef struct packed {
		keyRow_t row;
		keyColumn_t column;
	} bbcKey_t;

	typedef struct packed {
		bbcKey_t key;
		logic pressed; // 0 on release
	} keyEvent_t;

endpackage

`default_nettype wire

// ==== common/ps2Pkg.sv ====
`default_nettype none

package ps2Pkg;

	// start, eight data bits LSB first, odd parity, stop
	localparam int FRAME_BITS = 11;

	localparam int RELEASE_BIT = 7; // set-1 break flag

	typedef logic [7:0] scanCode_t;

	localparam scanCode_t PREFIX_EXTENDED = 8'hE0;

	// field order follows the wire, last bit received is the MSB
	typedef struct packed {
		logic stop;
		logic parity;
		scanCode_t data;
		logic start;
	} ps2Frame_t;

endpackage

`default_nettype wire
